//--- logic/blaster_pkg.sv
`default_nettype none

package blaster_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Keypad
	////////////////////////////////////////////////////////////////////////////

	// Codes as reported by the scanner
	typedef enum logic [3:0] {
		key_fire   = 4'h0,
		key_tone_1 = 4'h1,
		key_tone_2 = 4'h2,
		key_tone_3 = 4'h3,
		key_tone_4 = 4'h4,
		key_tone_5 = 4'h5,
		key_tone_6 = 4'h6,
		key_tone_7 = 4'h7,
		key_tone_8 = 4'h8,
		key_res    = 4'h9, // Resistance key, no function
		key_charge = 4'hA,
		key_dump   = 4'hB
	} key_code_e;

	typedef struct packed {
		logic      pressed; // High while a key is held
		key_code_e code;
	} key_t;

	// Board switches, all active low
	typedef struct packed {
		logic tone_n;
		logic dump_n;
		logic charge_n;
	} switch_t;

	////////////////////////////////////////////////////////////////////////////
	// Speaker tones
	////////////////////////////////////////////////////////////////////////////

	typedef logic [15:0] half_period_t;

	localparam int tone_count = 8;

	// Reload counts for keys 1 to 8
	localparam half_period_t tone_half_period [tone_count] = '{
		16'h2CCA,
		16'h27E7,
		16'h238D,
		16'h218E,
		16'h1DE5,
		16'h1AA2,
		16'h17BA,
		16'h1665
	};

	////////////////////////////////////////////////////////////////////////////
	// Current sense
	////////////////////////////////////////////////////////////////////////////

	typedef logic [11:0] current_t;

	// Sample is inverted below midscale, bit 11 set means no current
	localparam current_t current_mag_mask = 12'h7FF;

	// About 205 counts per amp, 2 A target with 10 percent band
	localparam current_t current_high_limit = 12'd430;
	localparam current_t current_low_limit  = 12'd390;

endpackage

`default_nettype wire

//--- logic/key_scan.sv
`default_nettype none

module key_scan #(
	parameter int scan_bits = 12
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [6:0]        keypad_in,
	output logic [6:0]        keypad_out,
	output blaster_pkg::key_t key
);
	import blaster_pkg::*;

	localparam int slot_bits = scan_bits - 2;

	// Column sample point, a few cycles before the row changes
	localparam logic [slot_bits-1:0] sample_point = {{(slot_bits - 2){1'b1}}, 2'b00};

	logic [scan_bits-1:0] div;
	logic [1:0]           row_sel;
	logic [slot_bits-1:0] slot_pos;
	logic [2:0]           col_n;     // Left, middle, right
	logic                 frame_hit; // Press seen in the current frame
	logic                 hit;
	logic [1:0]           hit_row;
	logic [1:0]           hit_col;

	assign row_sel  = div[scan_bits-1 -: 2];
	assign slot_pos = div[slot_bits-1:0];
	assign col_n    = {keypad_in[2], keypad_in[0], keypad_in[4]};

	// Row-major keypad layout
	function automatic key_code_e decode_key(input logic [1:0] row, input logic [1:0] col);
		key_code_e code;
		case ({row, col})
			4'b00_00: code = key_tone_1;
			4'b00_01: code = key_tone_2;
			4'b00_10: code = key_tone_3;
			4'b01_00: code = key_tone_4;
			4'b01_01: code = key_tone_5;
			4'b01_10: code = key_tone_6;
			4'b10_00: code = key_tone_7;
			4'b10_01: code = key_tone_8;
			4'b10_10: code = key_res;
			4'b11_00: code = key_charge;
			4'b11_01: code = key_fire;
			4'b11_10: code = key_dump;
			default:  code = key_res;
		endcase
		return code;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Divider and row drive
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			div        <= '0;
			keypad_out <= 7'h7F;
		end else begin
			div           <= div + 1'b1;
			keypad_out[1] <= (row_sel != 2'd0); // Row 0
			keypad_out[6] <= (row_sel != 2'd1);
			keypad_out[5] <= (row_sel != 2'd2);
			keypad_out[3] <= (row_sel != 2'd3); // Row 3
			// Column pads stay high
			keypad_out[0] <= 1'b1;
			keypad_out[2] <= 1'b1;
			keypad_out[4] <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Column capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_hit <= 1'b0;
			hit       <= 1'b0;
			hit_row   <= '0;
			hit_col   <= '0;
		end else if (div == '0) begin
			frame_hit <= 1'b0; // New frame
		end else if (&div && !frame_hit) begin
			hit <= 1'b0; // Frame passed with no press
		end else if (slot_pos == sample_point && col_n != 3'b111 && !frame_hit) begin
			frame_hit <= 1'b1;
			hit       <= 1'b1;
			hit_row   <= row_sel;
			// Leftmost low column wins
			hit_col   <= !col_n[2] ? 2'd0 : !col_n[1] ? 2'd1 : 2'd2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			key <= '0;
		end else if (hit) begin
			key.pressed <= 1'b1;
			key.code    <= decode_key(hit_row, hit_col);
		end else begin
			key <= '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/tone_gen.sv
`default_nettype none

module tone_gen (
	input  logic              clk,
	input  logic              reset,
	input  blaster_pkg::key_t key,
	output logic              speaker,
	output logic              speaker_n
);
	import blaster_pkg::*;

	half_period_t count;
	logic         tone_key;
	logic [2:0]   tone_idx;
	logic         spk_en;
	logic         spk_toggle;

	// Only keys 1 to 8 make a sound
	assign tone_key = key.pressed && key.code >= key_tone_1 && key.code <= key_tone_8;
	assign tone_idx = key.code[2:0] - 3'd1; // Key 8 wraps to entry 7

	////////////////////////////////////////////////////////////////////////////
	// Half-period counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			count      <= '0;
			spk_en     <= 1'b0;
			spk_toggle <= 1'b0;
		end else if (count == '0) begin
			spk_toggle <= ~spk_toggle;
			spk_en     <= tone_key;
			if (tone_key) begin
				count <= tone_half_period[tone_idx];
			end else begin
				count <= '0; // Idle, recheck next cycle
			end
		end else begin
			count <= count - 1'b1;
		end
	end

	// Differential drive doubles the swing across the speaker
	assign speaker   = spk_toggle & spk_en;
	assign speaker_n = ~speaker;

endmodule

`default_nettype wire

//--- logic/pulse_gen.sv
`default_nettype none

module pulse_gen #(
	parameter int trigger_bits = 16,
	parameter int min_width    = 48,
	parameter int max_width    = 768
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fire_button,
	input  blaster_pkg::key_t     key,
	input  blaster_pkg::current_t current,
	output logic                  pwm
);
	import blaster_pkg::*;

	localparam int time_bits = $clog2(max_width + 1);

	localparam logic [time_bits-1:0] min_time = time_bits'(min_width);
	localparam logic [time_bits-1:0] max_time = time_bits'(max_width);

	logic [time_bits-1:0]    pulse_time;  // High time, then low time
	logic [1:0]              pulse_count; // Pulses left in the burst
	logic [trigger_bits-1:0] retrigger;
	current_t                magnitude;
	logic                    over_limit;
	logic                    under_limit;
	logic                    fire_req;
	logic                    trigger;

	////////////////////////////////////////////////////////////////////////////
	// Current compare
	////////////////////////////////////////////////////////////////////////////

	// Bit 11 set reads as zero current
	assign magnitude   = current[11] ? '0 : (current ^ current_mag_mask);
	assign over_limit  = magnitude > current_high_limit;
	assign under_limit = magnitude < current_low_limit;

	// Fire input only counts once per retrigger period
	assign fire_req = fire_button || (key.pressed && key.code == key_fire);
	assign trigger  = fire_req && retrigger == '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			retrigger <= '0;
		end else begin
			retrigger <= retrigger + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Burst control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pwm         <= 1'b0;
			pulse_time  <= '0;
			pulse_count <= '0;
		end else if (pwm) begin
			if (pulse_time < min_time) begin
				pulse_time <= pulse_time + 1'b1; // Minimum on time
			end else if (pulse_time >= max_time || over_limit) begin
				pwm         <= 1'b0;
				pulse_time  <= '0;
				pulse_count <= pulse_count - 1'b1;
			end else begin
				pulse_time <= pulse_time + 1'b1;
			end
		end else if (pulse_count != '0) begin
			// Low gap, then wait for the coil current to decay
			if (pulse_time < min_time) begin
				pulse_time <= pulse_time + 1'b1;
			end else if (under_limit) begin
				pwm        <= 1'b1;
				pulse_time <= time_bits'(1);
			end
		end else if (trigger) begin
			pwm         <= 1'b1;
			pulse_time  <= time_bits'(1);
			pulse_count <= 2'd3;
		end else begin
			pulse_time <= '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/blaster_ctrl.sv
`default_nettype none

module blaster_ctrl #(
	parameter int scan_bits    = 12,
	parameter int trigger_bits = 16,
	parameter int min_width    = 48,
	parameter int max_width    = 768
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fire_button,
	input  blaster_pkg::switch_t  switches,
	input  logic                  cont_n,
	input  logic                  lt3420_done,
	input  blaster_pkg::current_t current,
	input  logic [6:0]            keypad_in,
	output logic [6:0]            keypad_out,
	output blaster_pkg::key_t     key,
	output logic                  speaker,
	output logic                  speaker_n,
	output logic                  pwm,
	output logic                  dump,
	output logic                  lt3420_charge,
	output logic                  arm_led_n,
	output logic                  cont_led_n
);
	import blaster_pkg::*;

	logic dump_key;
	logic charge_key;

	////////////////////////////////////////////////////////////////////////////
	// Keypad, speaker and pulse burst
	////////////////////////////////////////////////////////////////////////////

	key_scan #(
		.scan_bits(scan_bits)
	) i_key_scan (
		.clk       (clk),
		.reset     (reset),
		.keypad_in (keypad_in),
		.keypad_out(keypad_out),
		.key       (key)
	);

	tone_gen i_tone_gen (
		.clk      (clk),
		.reset    (reset),
		.key      (key),
		.speaker  (speaker),
		.speaker_n(speaker_n)
	);

	pulse_gen #(
		.trigger_bits(trigger_bits),
		.min_width   (min_width),
		.max_width   (max_width)
	) i_pulse_gen (
		.clk        (clk),
		.reset      (reset),
		.fire_button(fire_button),
		.key        (key),
		.current    (current),
		.pwm        (pwm)
	);

	// Charger and dump follow either the switch or the keypad
	assign dump_key   = key.pressed && key.code == key_dump;
	assign charge_key = key.pressed && key.code == key_charge;

	assign dump          = !switches.dump_n || dump_key;
	assign lt3420_charge = !switches.charge_n || charge_key;

	// LEDs are active low
	assign cont_led_n = !(switches.dump_n && cont_n); // Lit with no dump and open loop
	assign arm_led_n  = !(fire_button || lt3420_done);

endmodule

`default_nettype wire

//--- tb/blaster_ctrl_asserts.sv
`default_nettype none

module blaster_ctrl_asserts #(
	parameter int max_width = 768
) (
	input logic clk,
	input logic reset,
	input logic pwm,
	input logic speaker,
	input logic speaker_n
);
	timeunit 1ns;
	timeprecision 1ps;

	int pwm_run; // High cycles before the current one

	always_ff @(posedge clk) begin
		if (reset || !pwm) begin
			pwm_run <= 0;
		end else begin
			pwm_run <= pwm_run + 1;
		end
	end

	pwm_width: assert property (@(posedge clk) disable iff (reset) pwm |-> pwm_run < max_width)
		else $error("pwm high for more than %0d cycles", max_width);

	speaker_pair: assert property (@(posedge clk) disable iff (reset) speaker_n == !speaker)
		else $error("speaker_n is not the inverse of speaker");

	pwm_reset: assert property (@(posedge clk) reset |=> !pwm)
		else $error("pwm high right after reset");

endmodule

// Pulse side and speaker side each get a copy
bind pulse_gen blaster_ctrl_asserts #(.max_width(max_width)) i_pulse_asserts (
	.clk      (clk),
	.reset    (reset),
	.pwm      (pwm),
	.speaker  (1'b0),
	.speaker_n(1'b1)
);

bind tone_gen blaster_ctrl_asserts i_tone_asserts (
	.clk      (clk),
	.reset    (reset),
	.pwm      (1'b0),
	.speaker  (speaker),
	.speaker_n(speaker_n)
);

`default_nettype wire

//--- tb/blaster_ctrl_tb.sv
`default_nettype none

module blaster_ctrl_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import blaster_pkg::*;

	localparam int scan_bits    = 6;
	localparam int trigger_bits = 8;
	localparam int min_width    = 48;
	localparam int max_width    = 768;
	localparam int key_timeout  = 4 << scan_bits; // Scanner needs up to two frames
	localparam int fire_timeout = (1 << trigger_bits) + 16;
	localparam int tone_timeout = 20000;

	localparam current_t no_current   = 12'h800; // Bit 11 set
	localparam current_t high_current = 12'h629; // Magnitude 470
	localparam current_t mid_current  = 12'h665; // Magnitude 410

	logic       clk;
	logic       reset;
	logic       fire_button;
	switch_t    switches;
	logic       cont_n;
	logic       lt3420_done;
	current_t   current;
	logic [6:0] keypad_in;
	logic [6:0] keypad_out;
	key_t       key;
	logic       speaker;
	logic       speaker_n;
	logic       pwm;
	logic       dump;
	logic       lt3420_charge;
	logic       arm_led_n;
	logic       cont_led_n;
	logic       key_held;
	key_code_e  held_code;
	integer     seed;

	blaster_ctrl #(
		.scan_bits   (scan_bits),
		.trigger_bits(trigger_bits)
	) i_blaster_ctrl (
		.clk          (clk),
		.reset        (reset),
		.fire_button  (fire_button),
		.switches     (switches),
		.cont_n       (cont_n),
		.lt3420_done  (lt3420_done),
		.current      (current),
		.keypad_in    (keypad_in),
		.keypad_out   (keypad_out),
		.key          (key),
		.speaker      (speaker),
		.speaker_n    (speaker_n),
		.pwm          (pwm),
		.dump         (dump),
		.lt3420_charge(lt3420_charge),
		.arm_led_n    (arm_led_n),
		.cont_led_n   (cont_led_n)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Keypad matrix model
	////////////////////////////////////////////////////////////////////////////

	// Row pads 1, 6, 5, 3 from the top
	function automatic int row_pin(key_code_e code);
		case (code)
			key_tone_1, key_tone_2, key_tone_3: return 1;
			key_tone_4, key_tone_5, key_tone_6: return 6;
			key_tone_7, key_tone_8, key_res:    return 5;
			default:                            return 3;
		endcase
	endfunction

	function automatic int col_pin(key_code_e code);
		case (code)
			key_tone_1, key_tone_4, key_tone_7, key_charge: return 2; // Left
			key_tone_2, key_tone_5, key_tone_8, key_fire:   return 0;
			default:                                        return 4; // Right
		endcase
	endfunction

	// A closed switch shorts its column to the row pad
	always_comb begin
		keypad_in = 7'h7F;
		if (key_held) begin
			keypad_in[col_pin(held_code)] = keypad_out[row_pin(held_code)];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	////////////////////////////////////////////////////////////////////////////

	function automatic half_period_t expected_half_period(key_code_e code);
		case (code)
			key_tone_1: return 16'h2CCA;
			key_tone_2: return 16'h27E7;
			key_tone_3: return 16'h238D;
			key_tone_4: return 16'h218E;
			key_tone_5: return 16'h1DE5;
			key_tone_6: return 16'h1AA2;
			key_tone_7: return 16'h17BA;
			key_tone_8: return 16'h1665;
			default:    return 16'h0000;
		endcase
	endfunction

	function automatic key_t expected_key(key_code_e code);
		key_t k;
		k.pressed = 1'b1;
		k.code    = code;
		return k;
	endfunction

	function automatic current_t current_magnitude(current_t sample);
		if (sample[11]) begin
			return '0;
		end
		return sample ^ 12'h7FF;
	endfunction

	// High time of a pulse that sees this sample throughout
	function automatic int expected_width(current_t sample);
		return (current_magnitude(sample) > current_high_limit) ? min_width : max_width;
	endfunction

	task automatic report_failure(string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_key(string name, key_t expected, key_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("CHECK FAILED %s expected %0h actual %0h",
				name, expected, actual));
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			report_failure($sformatf("CHECK FAILED %s expected %b actual %b",
				name, expected, actual));
		end
	endtask

	task automatic check_count(string name, int expected, int actual);
		if (actual != expected) begin
			report_failure($sformatf("CHECK FAILED %s expected %0d actual %0d",
				name, expected, actual));
		end
	endtask

	// Switch, key and LED outputs every cycle
	always @(negedge clk) begin
		logic dump_key;
		logic charge_key;
		dump_key   = key_held && held_code == key_dump;
		charge_key = key_held && held_code == key_charge;
		if (!reset) begin
			check_bit("speaker_n", !speaker, speaker_n);
			check_bit("cont_led_n", !(switches.dump_n && cont_n), cont_led_n);
			check_bit("arm_led_n", !(fire_button || lt3420_done), arm_led_n);
			// Key outputs lag the keypad while the scanner catches up
			if (key.pressed === key_held) begin
				check_bit("dump", !switches.dump_n || dump_key, dump);
				check_bit("lt3420_charge", !switches.charge_n || charge_key, lt3420_charge);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Wait helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_key(logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (key.pressed !== level) begin
			n++;
			if (n > key_timeout) report_failure("Key scanner did not follow the keypad");
			@(negedge clk);
		end
	endtask

	task automatic press_key(key_code_e code);
		@(posedge clk);
		#1;
		held_code = code;
		key_held  = 1'b1;
		wait_key(1'b1);
		check_key("key press", expected_key(code), key);
	endtask

	task automatic release_key();
		@(posedge clk);
		#1 key_held = 1'b0;
		wait_key(1'b0);
	endtask

	task automatic wait_pwm(logic level, int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (pwm !== level) begin
			n++;
			if (n > limit) report_failure("pwm did not change in time");
			@(negedge clk);
		end
	endtask

	// Length of the current pwm level, counted from the present negedge
	task automatic count_run(logic level, int start, output int cycles);
		cycles = start;
		@(negedge clk);
		while (pwm === level) begin
			cycles++;
			if (cycles > max_width + 16) report_failure("pwm stuck at one level");
			@(negedge clk);
		end
	endtask

	task automatic pwm_stays_low(string name, int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_bit(name, 1'b0, pwm);
		end
	endtask

	task automatic next_speaker_edge(output int cycles);
		logic last;
		last   = speaker;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > tone_timeout) report_failure("No speaker edge while a tone key is held");
		end while (speaker === last);
	endtask

	task automatic speaker_stays_low(int cycles);
		int n;
		n = 0;
		while (speaker !== 1'b0) begin
			n++;
			if (n > tone_timeout) report_failure("Speaker did not go quiet");
			@(negedge clk);
		end
		repeat (cycles) begin
			@(negedge clk);
			check_bit("speaker idle", 1'b0, speaker);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		key_code_e all_keys [12];
		key_code_e swap;
		int        j;
		int        cycles;
		seed        = 32'hd42a;
		reset       = 1'b1;
		fire_button = 1'b0;
		switches    = '1;
		cont_n      = 1'b1;
		lt3420_done = 1'b0;
		current     = no_current;
		key_held    = 1'b0;
		held_code   = key_fire;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;

		@(negedge clk);
		check_bit("pwm after reset", 1'b0, pwm);
		check_bit("speaker after reset", 1'b0, speaker);
		check_bit("key after reset", 1'b0, key.pressed);
		check_bit("dump after reset", 1'b0, dump);
		check_bit("charge after reset", 1'b0, lt3420_charge);
		check_bit("cont led after reset", 1'b0, cont_led_n);
		check_bit("arm led after reset", 1'b1, arm_led_n);
		speaker_stays_low(2000);

		// Every key once, shuffled
		all_keys = '{key_fire, key_tone_1, key_tone_2, key_tone_3, key_tone_4, key_tone_5,
			key_tone_6, key_tone_7, key_tone_8, key_res, key_charge, key_dump};
		for (int i = 11; i > 0; i--) begin
			j           = $unsigned($random(seed)) % (i + 1);
			swap        = all_keys[i];
			all_keys[i] = all_keys[j];
			all_keys[j] = swap;
		end
		foreach (all_keys[i]) begin
			press_key(all_keys[i]);
			release_key();
		end

		// First edge may still end an old half period
		for (int t = 1; t <= 8; t++) begin
			press_key(key_code_e'(t));
			next_speaker_edge(cycles);
			next_speaker_edge(cycles);
			check_count($sformatf("tone %0d period", t),
				int'(expected_half_period(key_code_e'(t))) + 1, cycles);
			release_key();
		end
		speaker_stays_low(tone_timeout);

		// Burst with no coil current
		@(posedge clk);
		#1 fire_button = 1'b1;
		wait_pwm(1'b1, fire_timeout);
		@(posedge clk);
		#1 fire_button = 1'b0;
		for (int p = 1; p <= 3; p++) begin
			count_run(1'b1, 1, cycles);
			check_count($sformatf("pulse %0d high", p), expected_width(current), cycles);
			if (p < 3) begin
				count_run(1'b0, 1, cycles);
				check_count($sformatf("pulse %0d low", p), min_width + 1, cycles);
			end
		end
		pwm_stays_low("idle after burst", 600);

		// Current limit ends pulses early and holds off the next one
		@(posedge clk);
		#1;
		current     = high_current;
		fire_button = 1'b1;
		wait_pwm(1'b1, fire_timeout);
		@(posedge clk);
		#1 fire_button = 1'b0;
		count_run(1'b1, 1, cycles);
		check_count("limited pulse 1", expected_width(high_current), cycles);
		@(posedge clk);
		#1 current = mid_current;
		pwm_stays_low("hold off in band", 400);
		@(posedge clk);
		#1 current = no_current;
		wait_pwm(1'b1, 4);
		for (int p = 2; p <= 3; p++) begin
			@(posedge clk);
			#1 current = high_current;
			count_run(1'b1, 1, cycles);
			check_count($sformatf("limited pulse %0d", p), expected_width(high_current), cycles);
			if (p < 3) begin
				@(posedge clk);
				#1 current = no_current;
				count_run(1'b0, 1, cycles);
				check_count("limited gap", min_width + 1, cycles);
			end
		end
		pwm_stays_low("idle after limited burst", 600);
		@(posedge clk);
		#1 current = no_current;

		// Switches, keys and LEDs
		@(posedge clk);
		#1 switches.dump_n = 1'b0;
		@(negedge clk);
		check_bit("dump switch", 1'b1, dump);
		check_bit("cont led with dump", 1'b1, cont_led_n);
		@(posedge clk);
		#1;
		switches.dump_n   = 1'b1;
		switches.charge_n = 1'b0;
		@(negedge clk);
		check_bit("charge switch", 1'b1, lt3420_charge);
		@(posedge clk);
		#1 switches.charge_n = 1'b1;
		press_key(key_dump);
		check_bit("dump key", 1'b1, dump);
		release_key();
		press_key(key_charge);
		check_bit("charge key", 1'b1, lt3420_charge);
		release_key();
		@(posedge clk);
		#1 lt3420_done = 1'b1;
		@(negedge clk);
		check_bit("arm led when charged", 1'b0, arm_led_n);
		@(posedge clk);
		#1;
		lt3420_done = 1'b0;
		cont_n      = 1'b0;
		@(negedge clk);
		check_bit("cont led open loop", 1'b1, cont_led_n);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
logic/blaster_pkg.sv
logic/key_scan.sv
logic/tone_gen.sv
logic/pulse_gen.sv
logic/blaster_ctrl.sv
tb/blaster_ctrl_asserts.sv
tb/blaster_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module blaster_ctrl_tb -f project.f -o blaster_ctrl_sim

./obj_dir/blaster_ctrl_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "run.sh: simulation failed"
	exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "run.sh: simulation ended without a result"
	exit 1
fi

echo "run.sh: simulation passed"
